//--- Bender.yml
package:
  name: mem_steer

sources:
  - mem_steer_pkg.sv
  - mem_req_if.sv
  - reset_stretch.sv
  - steer_cfg.sv
  - access_decode.sv
  - access_router.sv
  - mem_steer_top.sv
  - target: simulation
    files:
      - mem_steer_checker.sv
      - tb_monitor.sv
      - tb_top.sv

//--- access_decode.sv
`default_nettype none

module access_decode (
    input  wire                               i_req_valid,
    input  wire mem_steer_pkg::mem_op_t       i_op,
    input  wire [mem_steer_pkg::ADDR_W-1:0]   i_addr,
    input  wire [mem_steer_pkg::ADDR_W-1:0]   i_wdata,
    mem_req_if.src                            o_req
);
    import mem_steer_pkg::*;

    acc_size_t  size;
    logic       is_write;
    logic [1:0] lo;

    assign lo = i_addr[1:0];

    always_comb begin
        is_write = 1'b0;
        size     = SIZE_WORD;
        case (i_op)
            OP_LB, OP_LBU: size = SIZE_BYTE;
            OP_LH, OP_LHU: size = SIZE_HALF;
            OP_LW:         size = SIZE_WORD;
            OP_SB: begin
                size     = SIZE_BYTE;
                is_write = 1'b1;
            end
            OP_SH: begin
                size     = SIZE_HALF;
                is_write = 1'b1;
            end
            default: begin
                size     = SIZE_WORD;
                is_write = 1'b1;
            end
        endcase
    end

    // Byte lanes and replicated store data
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                o_req.byte_en   = 4'b0001 << lo;
                o_req.wdata     = {4{i_wdata[7:0]}};
                o_req.align_err = 1'b0;
            end
            SIZE_HALF: begin
                o_req.byte_en   = lo[1] ? 4'b1100 : 4'b0011;
                o_req.wdata     = {2{i_wdata[15:0]}};
                o_req.align_err = lo[0];
            end
            default: begin
                o_req.byte_en   = 4'b1111;
                o_req.wdata     = i_wdata;
                o_req.align_err = |lo;
            end
        endcase
    end

    assign o_req.valid    = i_req_valid;
    assign o_req.is_write = is_write;
    assign o_req.addr     = i_addr;
    assign o_req.size     = size;

endmodule

`default_nettype wire

//--- access_router.sv
`default_nettype none

module access_router (
    input  wire                                Clk,
    input  wire                                i_core_reset,
    mem_req_if.dst                             i_req,
    input  wire                                i_exc,
    input  wire                                i_force_uncached,
    input  wire                                i_cache_closed,
    output logic                               o_cached_rd,
    output logic                               o_cached_wr,
    output logic                               o_uncached_rd,
    output logic                               o_uncached_wr,
    output logic [mem_steer_pkg::ADDR_W-1:0]   o_addr,
    output mem_steer_pkg::acc_size_t           o_size,
    output logic [3:0]                         o_byte_en,
    output logic [mem_steer_pkg::ADDR_W-1:0]   o_wdata,
    output logic                               o_align_err
);
    import mem_steer_pkg::*;

    logic uncached;
    logic take;
    logic issue;

    assign uncached = (i_req.addr[ADDR_W-1:ADDR_W-3] == UNCACHED_SEG)
                    | i_force_uncached
                    | i_cache_closed;

    // An exception in the same cycle kills the access outright
    assign take  = i_req.valid & ~i_exc;
    assign issue = take & ~i_req.align_err;

    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            o_cached_rd   <= 1'b0;
            o_cached_wr   <= 1'b0;
            o_uncached_rd <= 1'b0;
            o_uncached_wr <= 1'b0;
            o_align_err   <= 1'b0;
        end else begin
            o_cached_rd   <= issue & ~uncached & ~i_req.is_write;
            o_cached_wr   <= issue & ~uncached & i_req.is_write;
            o_uncached_rd <= issue & uncached & ~i_req.is_write;
            o_uncached_wr <= issue & uncached & i_req.is_write;
            o_align_err   <= take & i_req.align_err;
        end
    end

    // Payload follows every presented access
    always_ff @(posedge Clk) begin
        if (i_req.valid) begin
            o_addr    <= i_req.addr;
            o_size    <= i_req.size;
            o_byte_en <= i_req.byte_en;
            o_wdata   <= i_req.wdata;
        end
    end

endmodule

`default_nettype wire

//--- mem_req_if.sv
`default_nettype none

interface mem_req_if;
    import mem_steer_pkg::*;

    logic              valid;
    logic              is_write;
    logic [ADDR_W-1:0] addr;
    acc_size_t         size;
    logic [3:0]        byte_en;
    logic [ADDR_W-1:0] wdata;
    logic              align_err;

    // Decoder side
    modport src (
        output valid, is_write, addr, size, byte_en, wdata, align_err
    );

    // Router side, accepts every strobe
    modport dst (
        input valid, is_write, addr, size, byte_en, wdata, align_err
    );

endinterface

`default_nettype wire

//--- mem_steer_checker.sv
`default_nettype none

module mem_steer_checker (
    input wire Clk,
    input wire Myreset,
    input wire i_core_reset,
    input wire i_cached_rd,
    input wire i_cached_wr,
    input wire i_uncached_rd,
    input wire i_uncached_wr,
    input wire i_align_err
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0] strobes;
    int         assert_errors;

    initial begin
        assert_errors = 0;
    end

    assign strobes = {i_cached_rd, i_cached_wr, i_uncached_rd, i_uncached_wr};

    strobe_onehot: assert property (@(posedge Clk) disable iff (Myreset)
        $onehot0(strobes))
        else begin
            assert_errors = assert_errors + 1;
            $error("more than one access strobe high");
        end

    // Registered outputs are cleared on every edge of the held reset
    reset_quiet: assert property (@(posedge Clk) disable iff (Myreset)
        i_core_reset |-> (strobes == 4'b0000) && !i_align_err)
        else begin
            assert_errors = assert_errors + 1;
            $error("strobe or alignment error during core reset");
        end

    err_no_strobe: assert property (@(posedge Clk) disable iff (Myreset)
        i_align_err |-> (strobes == 4'b0000))
        else begin
            assert_errors = assert_errors + 1;
            $error("alignment error together with a strobe");
        end

endmodule

`default_nettype wire

//--- mem_steer_pkg.sv
`default_nettype none

package mem_steer_pkg;

    localparam int ADDR_W = 32;
    localparam int INT_W = 6;

    // Core reset stays up this many cycles after the external reset
    localparam int CORE_RESET_CYCLES = 128;
    localparam int RST_CNT_W = $clog2(CORE_RESET_CYCLES);

    // Fetches to complete before the caches open
    localparam int WARMUP_FETCHES = 3;
    localparam int WARM_CNT_W = $clog2(WARMUP_FETCHES + 1);

    // kseg1 style segment, address bits 31..29
    localparam logic [2:0] UNCACHED_SEG = 3'b101;

    localparam int CFG_W = INT_W + 1;

    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LBU = 3'd1,
        OP_LH  = 3'd2,
        OP_LHU = 3'd3,
        OP_LW  = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_t;

    // Same code as the bus size field
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } acc_size_t;

endpackage

`default_nettype wire

//--- mem_steer_stim.txt
# v op addr wdata exc cfg_we cfg_wdata fetch ext_int | strb err int size be addr wdata
# strb is {cached_rd cached_wr uncached_rd uncached_wr}; addr ffffffff takes the next LCG address
1 4 00001000 00000000 0 0 00 0 00 2 0 0 2 f 00001000 00000000
1 7 a0000004 12345678 0 0 00 1 00 1 0 0 2 f a0000004 12345678
1 0 00001001 00000000 0 0 00 1 00 2 0 0 0 2 00001001 00000000
1 1 00001002 00000000 0 0 00 1 00 2 0 0 0 4 00001002 00000000
1 2 00001002 00000000 0 0 00 0 00 8 0 0 1 c 00001002 00000000
1 5 00001003 000000ab 0 0 00 0 00 4 0 0 0 8 00001003 abababab
1 6 00001000 0000beef 0 0 00 0 00 4 0 0 1 3 00001000 beefbeef
1 3 00001001 00000000 0 0 00 0 00 0 1 0 1 3 00001001 00000000
1 4 00001002 00000000 0 0 00 0 00 0 1 0 2 f 00001002 00000000
1 7 00001008 cafef00d 0 0 00 0 00 4 0 0 2 f 00001008 cafef00d
1 4 a0000010 00000000 0 0 00 0 00 2 0 0 2 f a0000010 00000000
1 5 00001000 00000055 1 0 00 0 00 0 0 0 0 0 00000000 00000000
1 2 00001003 00000000 1 0 00 0 00 0 0 0 0 0 00000000 00000000
1 4 00001004 00000000 0 1 01 0 00 8 0 0 2 f 00001004 00000000
1 7 00001004 11223344 0 0 00 0 00 1 0 0 2 f 00001004 11223344
0 0 00000000 00000000 0 1 0a 0 04 0 0 1 0 0 00000000 00000000
1 0 00001000 00000000 0 0 00 0 02 8 0 0 0 1 00001000 00000000
0 0 00000000 00000000 0 0 00 0 01 0 0 1 0 0 00000000 00000000
1 1 00001003 00000000 0 0 00 0 00 8 0 0 0 8 00001003 00000000
1 6 00001002 00001234 0 0 00 0 00 4 0 0 1 c 00001002 12341234
1 4 a0000020 00000000 0 0 00 0 00 2 0 0 2 f a0000020 00000000
1 3 ffffffff 00000000 0 0 00 0 00 8 0 0 1 c 000004a6 00000000
1 5 ffffffff 0000007e 0 0 00 0 00 4 0 0 0 2 00003c75 7e7e7e7e
1 4 ffffffff 00000000 0 0 00 0 00 8 0 0 2 f 000011f8 00000000
0 0 00000000 00000000 0 0 00 0 00 0 0 0 0 0 00000000 00000000

//--- mem_steer_top.sv
`default_nettype none

module mem_steer_top (
    input  wire                                Clk,
    input  wire                                Myreset,
    input  wire                                i_req_valid,
    input  wire mem_steer_pkg::mem_op_t        i_op,
    input  wire [mem_steer_pkg::ADDR_W-1:0]    i_addr,
    input  wire [mem_steer_pkg::ADDR_W-1:0]    i_wdata,
    input  wire                                i_exc,
    input  wire                                i_cfg_we,
    input  wire [mem_steer_pkg::CFG_W-1:0]     i_cfg_wdata,
    input  wire                                i_fetch_done,
    input  wire [mem_steer_pkg::INT_W-1:0]     i_ext_int,
    output logic                               o_cached_rd,
    output logic                               o_cached_wr,
    output logic                               o_uncached_rd,
    output logic                               o_uncached_wr,
    output logic [mem_steer_pkg::ADDR_W-1:0]   o_addr,
    output mem_steer_pkg::acc_size_t           o_size,
    output logic [3:0]                         o_byte_en,
    output logic [mem_steer_pkg::ADDR_W-1:0]   o_wdata,
    output logic                               o_align_err,
    output logic                               o_int_pending
);
    import mem_steer_pkg::*;

    logic core_reset;
    logic force_uncached;
    logic cache_closed;

    mem_req_if u_req_if ();

    reset_stretch u_reset_stretch (
        .Clk          (Clk),
        .Myreset      (Myreset),
        .o_core_reset (core_reset)
    );

    steer_cfg u_steer_cfg (
        .Clk              (Clk),
        .Myreset          (Myreset),
        .i_core_reset     (core_reset),
        .i_cfg_we         (i_cfg_we),
        .i_cfg_wdata      (i_cfg_wdata),
        .i_fetch_done     (i_fetch_done),
        .i_ext_int        (i_ext_int),
        .o_force_uncached (force_uncached),
        .o_cache_closed   (cache_closed),
        .o_int_pending    (o_int_pending)
    );

    access_decode u_access_decode (
        .i_req_valid (i_req_valid),
        .i_op        (i_op),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .o_req       (u_req_if.src)
    );

    access_router u_access_router (
        .Clk              (Clk),
        .i_core_reset     (core_reset),
        .i_req            (u_req_if.dst),
        .i_exc            (i_exc),
        .i_force_uncached (force_uncached),
        .i_cache_closed   (cache_closed),
        .o_cached_rd      (o_cached_rd),
        .o_cached_wr      (o_cached_wr),
        .o_uncached_rd    (o_uncached_rd),
        .o_uncached_wr    (o_uncached_wr),
        .o_addr           (o_addr),
        .o_size           (o_size),
        .o_byte_en        (o_byte_en),
        .o_wdata          (o_wdata),
        .o_align_err      (o_align_err)
    );

endmodule

`default_nettype wire

//--- reset_stretch.sv
`default_nettype none

module reset_stretch (
    input  wire  Clk,
    input  wire  Myreset,
    output logic o_core_reset
);
    import mem_steer_pkg::*;

    logic [RST_CNT_W-1:0] rst_cnt;
    logic                 hold_q;

    // Count out the quiet period once the external reset is gone
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            rst_cnt <= '0;
            hold_q  <= 1'b1;
        end else if (hold_q) begin
            rst_cnt <= rst_cnt + 1'b1;
            if (&rst_cnt) begin
                hold_q <= 1'b0;
            end
        end
    end

    assign o_core_reset = Myreset | hold_q;

endmodule

`default_nettype wire

//--- sim.f
mem_steer_pkg.sv
mem_req_if.sv
reset_stretch.sv
steer_cfg.sv
access_decode.sv
access_router.sv
mem_steer_top.sv
mem_steer_checker.sv
tb_monitor.sv
tb_top.sv

//--- steer_cfg.sv
`default_nettype none

module steer_cfg (
    input  wire                             Clk,
    input  wire                             Myreset,
    input  wire                             i_core_reset,
    input  wire                             i_cfg_we,
    input  wire [mem_steer_pkg::CFG_W-1:0]  i_cfg_wdata,
    input  wire                             i_fetch_done,
    input  wire [mem_steer_pkg::INT_W-1:0]  i_ext_int,
    output logic                            o_force_uncached,
    output logic                            o_cache_closed,
    output logic                            o_int_pending
);
    import mem_steer_pkg::*;

    logic [CFG_W-1:0]      cfg_q;
    logic [WARM_CNT_W-1:0] warm_cnt;
    logic [INT_W-1:0]      int_sample_q;
    logic [INT_W-1:0]      int_mask;

    // Bit 0 force uncached, bits 6..1 interrupt mask
    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            cfg_q <= '0;
        end else if (i_cfg_we) begin
            cfg_q <= i_cfg_wdata;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            warm_cnt <= WARM_CNT_W'(WARMUP_FETCHES);
        end else if (i_fetch_done && (warm_cnt != '0)) begin
            warm_cnt <= warm_cnt - 1'b1;
        end
    end

    // Interrupt lines sampled on the raw reset, like the pin synchroniser
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            int_sample_q <= '0;
        end else begin
            int_sample_q <= i_ext_int;
        end
    end

    assign int_mask = cfg_q[CFG_W-1:1];

    assign o_force_uncached = cfg_q[0];
    assign o_cache_closed   = (warm_cnt != '0);
    // Mask is zero while the core is held, so no pending leaks out
    assign o_int_pending    = |(int_sample_q & int_mask);

endmodule

`default_nettype wire

//--- tb_monitor.sv
`default_nettype none

module tb_monitor (
    input  wire                     Clk,
    input  wire                     i_check_en,
    input  wire [3:0]               i_exp_strb,
    input  wire                     i_exp_err,
    input  wire                     i_exp_int,
    input  wire [2:0]               i_exp_size,
    input  wire [3:0]               i_exp_be,
    input  wire [31:0]              i_exp_addr,
    input  wire [31:0]              i_exp_wdata,
    input  wire                     i_cached_rd,
    input  wire                     i_cached_wr,
    input  wire                     i_uncached_rd,
    input  wire                     i_uncached_wr,
    input  wire [31:0]              i_addr,
    input  wire mem_steer_pkg::acc_size_t i_size,
    input  wire [3:0]               i_byte_en,
    input  wire [31:0]              i_wdata,
    input  wire                     i_align_err,
    input  wire                     i_int_pending,
    output int                      o_checks,
    output int                      o_errors
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_steer_pkg::*;

    initial begin
        o_checks = 0;
        o_errors = 0;
    end

    task automatic compare_field(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        o_checks = o_checks + 1;
        if (act_val !== exp_val) begin
            o_errors = o_errors + 1;
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp_val, act_val);
        end
    endtask

    // Outputs settle after the rising edge, so compare in the low phase
    always @(negedge Clk) begin
        if (i_check_en) begin
            compare_field("o_cached_rd", 32'(i_exp_strb[3]), 32'(i_cached_rd));
            compare_field("o_cached_wr", 32'(i_exp_strb[2]), 32'(i_cached_wr));
            compare_field("o_uncached_rd", 32'(i_exp_strb[1]), 32'(i_uncached_rd));
            compare_field("o_uncached_wr", 32'(i_exp_strb[0]), 32'(i_uncached_wr));
            compare_field("o_align_err", 32'(i_exp_err), 32'(i_align_err));
            compare_field("o_int_pending", 32'(i_exp_int), 32'(i_int_pending));
            // Payload only means something with a strobe or an error
            if ((i_exp_strb != 4'b0000) || i_exp_err) begin
                compare_field("o_size", 32'(i_exp_size), 32'(i_size));
                compare_field("o_byte_en", 32'(i_exp_be), 32'(i_byte_en));
                compare_field("o_addr", i_exp_addr, i_addr);
                compare_field("o_wdata", i_exp_wdata, i_wdata);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_top.sv
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_steer_pkg::*;

    localparam int MAX_LINES = 64;

    logic Clk, Myreset;
    logic req_valid, exc, cfg_we, fetch_done;
    logic [2:0] op;
    logic [31:0] addr, wdata;
    logic [CFG_W-1:0] cfg_wdata;
    logic [INT_W-1:0] ext_int;
    logic cached_rd, cached_wr, uncached_rd, uncached_wr, align_err, int_pending;
    logic [31:0] out_addr, out_wdata;
    acc_size_t out_size;
    logic [3:0] out_be;
    logic check_en;
    logic [3:0] exp_strb, exp_be;
    logic exp_err, exp_int;
    logic [2:0] exp_size;
    logic [31:0] exp_addr, exp_wdata;
    logic [31:0] stim [MAX_LINES][16];
    logic [15:0] lcg_state;
    int n_lines, parse_errors, mon_checks, mon_errors;
    int cycle_cnt, cycle_limit;

    mem_steer_top UUT (
        .Clk(Clk), .Myreset(Myreset), .i_req_valid(req_valid), .i_op(mem_op_t'(op)),
        .i_addr(addr), .i_wdata(wdata), .i_exc(exc), .i_cfg_we(cfg_we),
        .i_cfg_wdata(cfg_wdata), .i_fetch_done(fetch_done), .i_ext_int(ext_int),
        .o_cached_rd(cached_rd), .o_cached_wr(cached_wr), .o_uncached_rd(uncached_rd),
        .o_uncached_wr(uncached_wr), .o_addr(out_addr), .o_size(out_size),
        .o_byte_en(out_be), .o_wdata(out_wdata), .o_align_err(align_err),
        .o_int_pending(int_pending)
    );

    bind mem_steer_top mem_steer_checker u_checker (
        .Clk(Clk), .Myreset(Myreset), .i_core_reset(core_reset),
        .i_cached_rd(o_cached_rd), .i_cached_wr(o_cached_wr),
        .i_uncached_rd(o_uncached_rd), .i_uncached_wr(o_uncached_wr),
        .i_align_err(o_align_err)
    );

    tb_monitor u_monitor (
        .Clk(Clk), .i_check_en(check_en), .i_exp_strb(exp_strb), .i_exp_err(exp_err),
        .i_exp_int(exp_int), .i_exp_size(exp_size), .i_exp_be(exp_be),
        .i_exp_addr(exp_addr), .i_exp_wdata(exp_wdata), .i_cached_rd(cached_rd),
        .i_cached_wr(cached_wr), .i_uncached_rd(uncached_rd), .i_uncached_wr(uncached_wr),
        .i_addr(out_addr), .i_size(out_size), .i_byte_en(out_be), .i_wdata(out_wdata),
        .i_align_err(align_err), .i_int_pending(int_pending),
        .o_checks(mon_checks), .o_errors(mon_errors)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    function automatic logic [15:0] lcg_next(input logic [15:0] state);
        return state * 16'd13 + 16'd7;
    endfunction

    task automatic read_stim();
        int fd, n;
        string line;
        logic [31:0] f [16];
        fd = $fopen("mem_steer_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file");
            parse_errors = parse_errors + 1;
        end else begin
            while (!$feof(fd) && (n_lines < MAX_LINES)) begin
                line = "";
                void'($fgets(line, fd));
                if ((line.len() > 1) && (line[0] != "#")) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    if (n == 16) begin
                        stim[n_lines] = f;
                        n_lines = n_lines + 1;
                    end else if (n > 0) begin
                        $display("Malformed stimulus line: %s", line);
                        parse_errors = parse_errors + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_line(input int k);
        req_valid = stim[k][0][0];
        op        = stim[k][1][2:0];
        // All ones in the address column takes the next generated address
        if (stim[k][2] == 32'hffff_ffff) begin
            lcg_state = lcg_next(lcg_state);
            addr = {16'h0000, lcg_state};
        end else begin
            addr = stim[k][2];
        end
        wdata      = stim[k][3];
        exc        = stim[k][4][0];
        cfg_we     = stim[k][5][0];
        cfg_wdata  = stim[k][6][CFG_W-1:0];
        fetch_done = stim[k][7][0];
        ext_int    = stim[k][8][INT_W-1:0];
    endtask

    task automatic load_expect(input int k);
        exp_strb  = stim[k][9][3:0];
        exp_err   = stim[k][10][0];
        exp_int   = stim[k][11][0];
        exp_size  = stim[k][12][2:0];
        exp_be    = stim[k][13][3:0];
        exp_addr  = stim[k][14];
        exp_wdata = stim[k][15];
    endtask

    task automatic drive_idle();
        req_valid = 1'b0;
        op = 3'd0;
        addr = '0;
        wdata = '0;
        exc = 1'b0;
        cfg_we = 1'b0;
        cfg_wdata = '0;
        fetch_done = 1'b0;
    endtask

    always @(posedge Clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        Myreset = 1'b1;
        ext_int = '1;
        drive_idle();
        check_en = 1'b0;
        exp_strb = 4'b0000;
        exp_err = 1'b0;
        exp_int = 1'b0;
        exp_size = 3'd0;
        exp_be = 4'b0000;
        exp_addr = '0;
        exp_wdata = '0;
        lcg_state = 16'd91;
        n_lines = 0;
        parse_errors = 0;
        cycle_cnt = 0;
        cycle_limit = CORE_RESET_CYCLES + 20;
        read_stim();
        cycle_limit = n_lines + CORE_RESET_CYCLES + 20;
        repeat (2) @(posedge Clk);
        #1 Myreset = 1'b0;
        check_en = 1'b1;
        // Requests, config writes and fetches up to the last held cycle stay invisible
        for (int i = 0; i < CORE_RESET_CYCLES - 1; i++) begin
            @(posedge Clk);
            #1;
            req_valid = 1'b1;
            op = 3'd7;
            addr = 32'h0000_2000;
            wdata = 32'h5a5a_5a5a;
            cfg_we = 1'b1;
            cfg_wdata = '1;
            fetch_done = 1'b1;
        end
        // First stimulus line lands in the first cycle out of core reset
        for (int k = 0; k <= n_lines; k++) begin
            @(posedge Clk);
            #1;
            if (k > 0) begin
                load_expect(k - 1);
            end
            if (k < n_lines) begin
                drive_line(k);
            end else begin
                drive_idle();
            end
        end
        @(negedge Clk);
        #1;
        $display("Checks: %0d, errors: %0d, stimulus errors: %0d, assertion errors: %0d",
                 mon_checks, mon_errors, parse_errors, UUT.u_checker.assert_errors);
        if ((mon_errors == 0) && (parse_errors == 0) &&
            (UUT.u_checker.assert_errors == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
